// ==== bench/ccu_tb.sv ====
// ****************************************
// Directed testbench for the CCU with a bus memory
// Runs reset, read, write, priority and stress tests
// ****************************************

`timescale 1ns/1ps

module ccu_tb;

    localparam int NUM_PORTS     = 2;
    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 5;
    localparam int MEM_WORDS     = 256;
    localparam int LINES         = MEM_WORDS / ccu_pkg::LINE_WORDS;
    localparam int STRESS_OPS    = 20;
    localparam int NUM_XFERS     = 6 + STRESS_OPS;
    localparam int WORD_CYCLES   = 6;
    localparam int MARGIN_CYCLES = 200;
    localparam int WATCHDOG_NS   =
        (NUM_XFERS * ccu_pkg::LINE_WORDS * WORD_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;
    localparam int SEED          = 41021;

    // One acknowledged word as seen on the memory bus
    typedef struct packed {
        logic                           we;
        logic [ccu_pkg::ADDR_WIDTH-1:0] addr;
        logic [ccu_pkg::WORD_WIDTH-1:0] wdata;
    } bus_word_t;

    logic                           clk;
    logic                           n_rst;
    logic [NUM_PORTS-1:0]           req_valid;
    ccu_pkg::ccu_req_t              req [0:NUM_PORTS-1];
    logic [NUM_PORTS-1:0]           req_done;
    ccu_pkg::ccu_line_t             rsp_line;
    logic                           bus_req;
    logic                           bus_we;
    logic [ccu_pkg::ADDR_WIDTH-1:0] bus_addr;
    logic [ccu_pkg::WORD_WIDTH-1:0] bus_wdata;
    logic                           bus_ack;
    logic [ccu_pkg::WORD_WIDTH-1:0] bus_rdata;

    logic [NUM_PORTS-1:0]           pending;
    logic [ccu_pkg::WORD_WIDTH-1:0] model_mem [0:MEM_WORDS-1];
    bus_word_t                      bus_log [$];
    string                          cur_test;
    int                             errors;
    int                             checks;
    int                             tests_run;
    int                             tests_failed;
    int unsigned                    rnd;

    clk_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) clk_gen_inst (
        .o_clk   (clk),
        .o_n_rst (n_rst)
    );

    ccu #(
        .OPTN_CCU_ARB_DEPTH (NUM_PORTS)
    ) ccu_inst (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_req_valid (req_valid),
        .i_req       (req),
        .o_req_done  (req_done),
        .o_rsp_line  (rsp_line),
        .o_bus_req   (bus_req),
        .o_bus_we    (bus_we),
        .o_bus_addr  (bus_addr),
        .o_bus_wdata (bus_wdata),
        .i_bus_ack   (bus_ack),
        .i_bus_rdata (bus_rdata)
    );

    mem_model #(
        .DEPTH (MEM_WORDS)
    ) mem_model_inst (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_bus_req   (bus_req),
        .i_bus_we    (bus_we),
        .i_bus_addr  (bus_addr),
        .i_bus_wdata (bus_wdata),
        .o_bus_ack   (bus_ack),
        .o_bus_rdata (bus_rdata)
    );

    task automatic check_line(string what, ccu_pkg::ccu_line_t exp, ccu_pkg::ccu_line_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch in %s (%s): expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch in %s (%s): expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic check_addr(string what, logic [ccu_pkg::ADDR_WIDTH-1:0] exp,
                              logic [ccu_pkg::ADDR_WIDTH-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch in %s (%s): expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_word(string what, logic [ccu_pkg::WORD_WIDTH-1:0] exp,
                              logic [ccu_pkg::WORD_WIDTH-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch in %s (%s): expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    // A done pulse is only legal on a port with a request outstanding
    always @(posedge clk) begin
        if (n_rst) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (req_done[i] === 1'b1 && !pending[i]) begin
                    errors++;
                    $display("Error in %s: done pulse on port %0d with no request pending",
                             cur_test, i);
                end
            end
        end
    end

    // Acknowledged words wait here until their line completes
    always @(posedge clk) begin
        if (n_rst && bus_req === 1'b1 && bus_ack === 1'b1) begin
            bus_log.push_back(bus_word_t'({bus_we, bus_addr, bus_wdata}));
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Error: watchdog expired after %0d ns, a request never completed",
                 WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

    // Expected line from the reference memory with word 0 in the low bits
    function automatic ccu_pkg::ccu_line_t model_line(logic [ccu_pkg::ADDR_WIDTH-1:0] addr);
        ccu_pkg::ccu_line_t line;
        int                 base;
        base = int'(addr >> 5) * ccu_pkg::LINE_WORDS;
        for (int k = 0; k < ccu_pkg::LINE_WORDS; k++) begin
            line[k*ccu_pkg::WORD_WIDTH +: ccu_pkg::WORD_WIDTH] = model_mem[base + k];
        end
        return line;
    endfunction

    function automatic void model_write(logic [ccu_pkg::ADDR_WIDTH-1:0] addr,
                                        ccu_pkg::ccu_line_t line);
        int base;
        base = int'(addr >> 5) * ccu_pkg::LINE_WORDS;
        for (int k = 0; k < ccu_pkg::LINE_WORDS; k++) begin
            model_mem[base + k] = line[k*ccu_pkg::WORD_WIDTH +: ccu_pkg::WORD_WIDTH];
        end
    endfunction

    function automatic ccu_pkg::ccu_line_t random_line();
        ccu_pkg::ccu_line_t line;
        for (int k = 0; k < ccu_pkg::LINE_WORDS; k++) begin
            line[k*ccu_pkg::WORD_WIDTH +: ccu_pkg::WORD_WIDTH] = $urandom;
        end
        return line;
    endfunction

    function automatic ccu_pkg::ccu_req_t make_req(logic we, int line_idx,
                                                   ccu_pkg::ccu_line_t data);
        ccu_pkg::ccu_req_t r;
        r.we   = we;
        r.addr = ccu_pkg::ADDR_WIDTH'(line_idx * ccu_pkg::LINE_BYTES);
        r.line = data;
        return r;
    endfunction

    // Word k of a line goes to the aligned line address plus 4k
    task automatic check_bus(ccu_pkg::ccu_req_t r);
        bus_word_t                      w;
        logic [ccu_pkg::ADDR_WIDTH-1:0] base;
        base = r.addr & ~ccu_pkg::ADDR_WIDTH'(ccu_pkg::LINE_BYTES - 1);
        if (bus_log.size() != ccu_pkg::LINE_WORDS) begin
            checks++;
            errors++;
            $display("Mismatch in %s (bus words per line): expected %0d, actual %0d",
                     cur_test, ccu_pkg::LINE_WORDS, bus_log.size());
            bus_log.delete();
        end else begin
            for (int k = 0; k < ccu_pkg::LINE_WORDS; k++) begin
                w = bus_log.pop_front();
                check_bit($sformatf("bus we word %0d", k), r.we, w.we);
                check_addr($sformatf("bus addr word %0d", k),
                           base + ccu_pkg::ADDR_WIDTH'(4 * k), w.addr);
                if (r.we) begin
                    check_word($sformatf("bus wdata word %0d", k),
                               r.line[k*ccu_pkg::WORD_WIDTH +: ccu_pkg::WORD_WIDTH],
                               w.wdata);
                end
            end
        end
    endtask

    // Called right after a rising edge
    task automatic start_req(int port, ccu_pkg::ccu_req_t r);
        req_valid[port] <= 1'b1;
        req[port]       <= r;
        pending[port]   <= 1'b1;
    endtask

    task automatic release_port(int port);
        req_valid[port] <= 1'b0;
        pending[port]   <= 1'b0;
    endtask

    task automatic wait_done(int port, output ccu_pkg::ccu_line_t line);
        do @(posedge clk); while (req_done[port] !== 1'b1);
        line = rsp_line;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (i != port) begin
                check_bit($sformatf("done on port %0d", i), 1'b0, req_done[i]);
            end
        end
        check_bit("bus idle at done", 1'b0, bus_req);
        release_port(port);
    endtask

    task automatic transfer(int port, ccu_pkg::ccu_req_t r, output ccu_pkg::ccu_line_t line);
        @(posedge clk);
        start_req(port, r);
        wait_done(port, line);
        check_bus(r);
        if (r.we) begin
            model_write(r.addr, r.line);
        end
    endtask

    task automatic finish_test(string name, int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("[%0t ns] test %s: ok", $time, name);
        end else begin
            tests_failed++;
            $display("[%0t ns] test %s: FAILED, %0d errors", $time, name,
                     errors - errors_before);
        end
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        cur_test = "reset";
        @(posedge clk);
        while (n_rst !== 1'b1) begin
            @(posedge clk);
            check_bit("done in reset", 1'b0, |req_done);
            check_bit("bus req in reset", 1'b0, bus_req);
        end
        repeat (2) begin
            @(posedge clk);
            check_bit("done after reset", 1'b0, |req_done);
            check_bit("bus req after reset", 1'b0, bus_req);
        end
        finish_test(cur_test, e0);
    endtask

    task automatic test_read_port0();
        ccu_pkg::ccu_req_t  r;
        ccu_pkg::ccu_line_t line;
        int                 e0;
        e0 = errors;
        cur_test = "read port 0";
        r = make_req(1'b0, 3, '0);
        transfer(0, r, line);
        check_line("line 3", model_line(r.addr), line);
        finish_test(cur_test, e0);
    endtask

    task automatic test_write_read_port1();
        ccu_pkg::ccu_line_t data;
        ccu_pkg::ccu_line_t line;
        int                 e0;
        e0 = errors;
        cur_test = "write then read port 1";
        data = random_line();
        transfer(1, make_req(1'b1, 5, data), line);
        transfer(1, make_req(1'b0, 5, '0), line);
        check_line("line 5 readback", data, line);
        // Neighbour must keep its old content
        transfer(1, make_req(1'b0, 6, '0), line);
        check_line("line 6 untouched", model_line(6 * ccu_pkg::LINE_BYTES), line);
        finish_test(cur_test, e0);
    endtask

    task automatic test_priority();
        ccu_pkg::ccu_req_t  r0;
        ccu_pkg::ccu_req_t  r1;
        ccu_pkg::ccu_line_t line0;
        ccu_pkg::ccu_line_t line1;
        logic               got0;
        logic               got1;
        logic               order_ok;
        int                 e0;
        e0 = errors;
        cur_test = "priority";
        got0 = 1'b0;
        got1 = 1'b0;
        order_ok = 1'b1;
        r0 = make_req(1'b0, 7, '0);
        r1 = make_req(1'b0, 9, '0);
        @(posedge clk);
        start_req(0, r0);
        start_req(1, r1);
        while (!(got0 && got1)) begin
            @(posedge clk);
            if (req_done[0] === 1'b1) begin
                line0 = rsp_line;
                got0 = 1'b1;
                release_port(0);
                check_bus(r0);
            end
            if (req_done[1] === 1'b1) begin
                order_ok = order_ok && got0;
                line1 = rsp_line;
                got1 = 1'b1;
                release_port(1);
                check_bus(r1);
            end
        end
        check_bit("port 0 served first", 1'b1, order_ok);
        check_line("port 0 line", model_line(7 * ccu_pkg::LINE_BYTES), line0);
        check_line("port 1 line", model_line(9 * ccu_pkg::LINE_BYTES), line1);
        finish_test(cur_test, e0);
    endtask

    task automatic test_stress();
        ccu_pkg::ccu_req_t  r;
        ccu_pkg::ccu_line_t line;
        int                 port;
        int                 e0;
        e0 = errors;
        cur_test = "stress";
        for (int n = 0; n < STRESS_OPS; n++) begin
            port = $urandom % NUM_PORTS;
            r = make_req(1'($urandom % 2), $urandom % LINES, random_line());
            // Offset bits inside the line must be ignored
            r.addr[4:0] = 5'($urandom);
            transfer(port, r, line);
            if (!r.we) begin
                check_line($sformatf("op %0d read %h", n, r.addr), model_line(r.addr), line);
            end
        end
        finish_test(cur_test, e0);
    endtask

    initial begin
        rnd = $urandom(SEED);
        req_valid = '0;
        pending = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            req[i] = '0;
        end
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        cur_test = "none";
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = ccu_pkg::WORD_WIDTH'(i * 4) ^ 32'hA5A5A5A5;
        end

        test_reset();
        test_read_port0();
        test_write_read_port1();
        test_priority();
        test_stress();

        $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== bench/clk_gen.sv ====
// ****************************************
// Testbench clock and synchronous reset
// ****************************************

`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 5
)(
    output logic o_clk,
    output logic o_n_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Release on a rising edge so the DUT sees a clean first active cycle
    initial begin
        o_n_rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_n_rst <= 1'b1;
    end

endmodule

// ==== bench/mem_model.sv ====
// ****************************************
// Word memory on the CCU bus for the testbench
// Acks each word after 0 to 3 random wait cycles
// ****************************************

`timescale 1ns/1ps

module mem_model #(
    parameter int DEPTH = 256
)(
    input  logic                            clk,
    input  logic                            n_rst,
    input  logic                            i_bus_req,
    input  logic                            i_bus_we,
    input  logic [ccu_pkg::ADDR_WIDTH-1:0]  i_bus_addr,
    input  logic [ccu_pkg::WORD_WIDTH-1:0]  i_bus_wdata,
    output logic                            o_bus_ack,
    output logic [ccu_pkg::WORD_WIDTH-1:0]  o_bus_rdata
);

    localparam int IDX_WIDTH = $clog2(DEPTH);

    logic [ccu_pkg::WORD_WIDTH-1:0] mem [0:DEPTH-1];
    logic [IDX_WIDTH-1:0]           idx;
    logic                           waiting;
    logic [1:0]                     wait_cnt;
    int unsigned                    delay;

    assign idx = i_bus_addr[IDX_WIDTH+1:2];

    // Each word holds its own byte address scrambled
    initial begin
        o_bus_ack   = 1'b0;
        o_bus_rdata = '0;
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = ccu_pkg::WORD_WIDTH'(i * 4) ^ 32'hA5A5A5A5;
        end
    end

    always @(posedge clk) begin
        if (!n_rst) begin
            o_bus_ack <= 1'b0;
            waiting   <= 1'b0;
            wait_cnt  <= '0;
        end else if (o_bus_ack) begin
            // BIU moves to the next word on this edge
            o_bus_ack <= 1'b0;
        end else if (waiting && wait_cnt != 0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end else if (waiting || i_bus_req) begin
            delay = waiting ? 0 : $urandom % 4;
            if (delay == 0) begin
                waiting     <= 1'b0;
                o_bus_ack   <= 1'b1;
                o_bus_rdata <= mem[idx];
                if (i_bus_we) begin
                    mem[idx] <= i_bus_wdata;
                end
            end else begin
                waiting  <= 1'b1;
                wait_cnt <= 2'(delay - 1);
            end
        end
    end

endmodule

// ==== biu/biu.sv ====
// ****************************************
// Bus interface unit, one line as eight word transfers
// Started by a level enable, finishes with a done pulse
// ****************************************

`timescale 1ns/1ps

module biu (
    input  logic                            clk,
    input  logic                            n_rst,

    // Arbiter side
    input  logic                            i_biu_en,
    input  ccu_pkg::ccu_req_t               i_biu_req,
    output logic                            o_biu_done,
    output ccu_pkg::ccu_line_t              o_biu_line,

    // Memory bus
    output logic                            o_bus_req,
    output logic                            o_bus_we,
    output logic [ccu_pkg::ADDR_WIDTH-1:0]  o_bus_addr,
    output logic [ccu_pkg::WORD_WIDTH-1:0]  o_bus_wdata,
    input  logic                            i_bus_ack,
    input  logic [ccu_pkg::WORD_WIDTH-1:0]  i_bus_rdata
);

    localparam int OFFSET_WIDTH = $clog2(ccu_pkg::LINE_BYTES);
    localparam int WORD_BYTES   = ccu_pkg::WORD_WIDTH / 8;

    typedef enum logic [1:0] {
        BIU_IDLE = 2'b00,
        BIU_XFER = 2'b01,
        BIU_WAIT = 2'b10
    } biu_state_t;

    biu_state_t                          state;
    logic                                accept;
    logic                                word_done;
    logic                                last_word;
    logic [ccu_pkg::WORD_IDX_WIDTH-1:0]  word_idx;
    logic                                we_q;
    logic [ccu_pkg::ADDR_WIDTH-1:0]      addr_q;
    ccu_pkg::ccu_line_t                  line_q;
    logic [ccu_pkg::WORD_WIDTH-1:0]      top_word;

    assign accept    = (state == BIU_IDLE) && i_biu_en;
    assign word_done = (state == BIU_XFER) && i_bus_ack;
    assign last_word = (word_idx == ccu_pkg::WORD_IDX_WIDTH'(ccu_pkg::LINE_WORDS - 1));

    // Reads fill the top slot, writes just drain
    assign top_word = we_q ? '0 : i_bus_rdata;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state <= BIU_IDLE;
        end else begin
            case (state)
                BIU_IDLE: begin
                    if (i_biu_en) begin
                        state <= BIU_XFER;
                    end
                end
                BIU_XFER: begin
                    if (i_bus_ack && last_word) begin
                        state <= BIU_WAIT;
                    end
                end
                // Hold off until the arbiter drops enable
                BIU_WAIT: begin
                    if (!i_biu_en) begin
                        state <= BIU_IDLE;
                    end
                end
                default: state <= BIU_IDLE;
            endcase
        end
    end

    // Word counter
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            word_idx <= '0;
        end else if (accept) begin
            word_idx <= '0;
        end else if (word_done) begin
            word_idx <= word_idx + 1'b1;
        end
    end

    // Bus request stays up across words until the last ack
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_bus_req <= 1'b0;
        end else if (accept) begin
            o_bus_req <= 1'b1;
        end else if (word_done && last_word) begin
            o_bus_req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_biu_done <= 1'b0;
        end else begin
            o_biu_done <= word_done && last_word;
        end
    end

    // Address and line shift register
    always_ff @(posedge clk) begin
        if (accept) begin
            we_q   <= i_biu_req.we;
            addr_q <= {i_biu_req.addr[ccu_pkg::ADDR_WIDTH-1:OFFSET_WIDTH],
                       OFFSET_WIDTH'(0)};
            line_q <= i_biu_req.line;
        end else if (word_done) begin
            addr_q <= addr_q + ccu_pkg::ADDR_WIDTH'(WORD_BYTES);
            line_q <= {top_word, line_q[ccu_pkg::LINE_WIDTH-1:ccu_pkg::WORD_WIDTH]};
        end
    end

    // After eight shifts word 0 of a read is back in the low slot
    assign o_biu_line  = line_q;

    assign o_bus_we    = we_q;
    assign o_bus_addr  = addr_q;
    assign o_bus_wdata = line_q[ccu_pkg::WORD_WIDTH-1:0];

endmodule

// ==== common/ccu_pkg.sv ====
// ****************************************
// Sizes and request types shared by the CCU blocks
// Referenced by scoped name, never imported
// ****************************************

package ccu_pkg;

    // Memory bus word and byte address
    localparam int WORD_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;

    // Cache line geometry
    localparam int LINE_BYTES     = 32;
    localparam int LINE_WORDS     = LINE_BYTES / (WORD_WIDTH / 8);
    localparam int LINE_WIDTH     = LINE_BYTES * 8;
    localparam int WORD_IDX_WIDTH = $clog2(LINE_WORDS);

    // Word k sits at bits [k*WORD_WIDTH +: WORD_WIDTH], word 0 lowest
    typedef logic [LINE_WIDTH-1:0] ccu_line_t;

    // One whole-line transfer from a requester
    // addr is line aligned, low offset bits are ignored
    typedef struct packed {
        logic                  we;
        logic [ADDR_WIDTH-1:0] addr;
        ccu_line_t             line;
    } ccu_req_t;

endpackage

// ==== rtl/ccu.sv ====
// ****************************************
// CCU top, arbiter feeding the bus interface unit
// ****************************************

`timescale 1ns/1ps

module ccu #(
    parameter int OPTN_CCU_ARB_DEPTH = 2
)(
    input  logic                            clk,
    input  logic                            n_rst,

    // Requesters
    input  logic [OPTN_CCU_ARB_DEPTH-1:0]   i_req_valid,
    input  ccu_pkg::ccu_req_t               i_req [0:OPTN_CCU_ARB_DEPTH-1],
    output logic [OPTN_CCU_ARB_DEPTH-1:0]   o_req_done,
    output ccu_pkg::ccu_line_t              o_rsp_line,

    // Memory bus
    output logic                            o_bus_req,
    output logic                            o_bus_we,
    output logic [ccu_pkg::ADDR_WIDTH-1:0]  o_bus_addr,
    output logic [ccu_pkg::WORD_WIDTH-1:0]  o_bus_wdata,
    input  logic                            i_bus_ack,
    input  logic [ccu_pkg::WORD_WIDTH-1:0]  i_bus_rdata
);

    logic               biu_en;
    logic               biu_done;
    ccu_pkg::ccu_req_t  biu_req;
    ccu_pkg::ccu_line_t biu_line;

    ccu_arb #(
        .OPTN_CCU_ARB_DEPTH (OPTN_CCU_ARB_DEPTH)
    ) ccu_arb_inst (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_req_valid (i_req_valid),
        .i_req       (i_req),
        .o_req_done  (o_req_done),
        .o_rsp_line  (o_rsp_line),
        .i_biu_done  (biu_done),
        .i_biu_line  (biu_line),
        .o_biu_en    (biu_en),
        .o_biu_req   (biu_req)
    );

    biu biu_inst (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_biu_en    (biu_en),
        .i_biu_req   (biu_req),
        .o_biu_done  (biu_done),
        .o_biu_line  (biu_line),
        .o_bus_req   (o_bus_req),
        .o_bus_we    (o_bus_we),
        .o_bus_addr  (o_bus_addr),
        .o_bus_wdata (o_bus_wdata),
        .i_bus_ack   (i_bus_ack),
        .i_bus_rdata (i_bus_rdata)
    );

endmodule

// ==== rtl/ccu_arb.sv ====
// ****************************************
// Fixed-priority arbiter in front of the BIU
// Lowest valid index wins, one line in flight
// ****************************************

`timescale 1ns/1ps

module ccu_arb #(
    parameter int OPTN_CCU_ARB_DEPTH = 2
)(
    input  logic                          clk,
    input  logic                          n_rst,

    // Requester side
    input  logic [OPTN_CCU_ARB_DEPTH-1:0] i_req_valid,
    input  ccu_pkg::ccu_req_t             i_req [0:OPTN_CCU_ARB_DEPTH-1],
    output logic [OPTN_CCU_ARB_DEPTH-1:0] o_req_done,
    output ccu_pkg::ccu_line_t            o_rsp_line,

    // BIU side
    input  logic                          i_biu_done,
    input  ccu_pkg::ccu_line_t            i_biu_line,
    output logic                          o_biu_en,
    output ccu_pkg::ccu_req_t             o_biu_req
);

    localparam int IDX_WIDTH = (OPTN_CCU_ARB_DEPTH > 1) ? $clog2(OPTN_CCU_ARB_DEPTH) : 1;

    typedef enum logic [1:0] {
        ARB_IDLE = 2'b00,
        ARB_BUSY = 2'b01,
        ARB_DONE = 2'b10
    } arb_state_t;

    arb_state_t                    state;
    arb_state_t                    state_next;
    logic [OPTN_CCU_ARB_DEPTH-1:0] select;
    logic                          any_valid;
    logic [IDX_WIDTH-1:0]          idx;
    logic [IDX_WIDTH-1:0]          idx_q;

    // Isolate the lowest set valid bit
    assign select    = i_req_valid & ~(i_req_valid - 1'b1);
    assign any_valid = |i_req_valid;

    // One-hot to binary
    always_comb begin
        idx = '0;
        for (int i = 0; i < OPTN_CCU_ARB_DEPTH; i++) begin
            if (select[i]) begin
                idx = IDX_WIDTH'(i);
            end
        end
    end

    // Grant only changes while idle, so a running job is never preempted
    always_ff @(posedge clk) begin
        if (state == ARB_IDLE) begin
            idx_q <= idx;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ARB_IDLE: begin
                if (any_valid) begin
                    state_next = ARB_BUSY;
                end
            end
            ARB_BUSY: begin
                if (i_biu_done) begin
                    state_next = ARB_DONE;
                end
            end
            ARB_DONE: state_next = ARB_IDLE;
            default:  state_next = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state <= ARB_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Enable drops on the edge that sees done
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_biu_en <= 1'b0;
        end else begin
            o_biu_en <= (state == ARB_BUSY) && !i_biu_done;
        end
    end

    // Granted request is held by its owner, so sampling every cycle is safe
    always_ff @(posedge clk) begin
        o_biu_req <= i_req[idx_q];
    end

    // Route the done pulse back to the granted port only
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_req_done <= '0;
        end else begin
            for (int i = 0; i < OPTN_CCU_ARB_DEPTH; i++) begin
                o_req_done[i] <= (state_next == ARB_DONE) && (idx_q == IDX_WIDTH'(i));
            end
        end
    end

    always_ff @(posedge clk) begin
        o_rsp_line <= i_biu_line;
    end

endmodule

// ==== sim.f ====
common/ccu_pkg.sv
rtl/ccu_arb.sv
biu/biu.sv
rtl/ccu.sv
bench/clk_gen.sv
bench/mem_model.sv
bench/ccu_tb.sv
